// ==== filelist.f ====
src/cpu_bus_pkg.sv
src/cpu_isa_pkg.sv
src/opcode_decoder.sv
src/alu.sv
src/register_file.sv
src/fetch_sequencer.sv
src/load_store_unit.sv
src/cpu_top.sv
verification/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the CPU slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim

# The log decides pass or fail
if ! ./obj_dir/cpu_tb_sim > sim.log 2>&1; then
  echo "Simulation exited with an error"
fi
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// ==== src/alu.sv ====
/*
  8-bit ALU
  Clear, increment, complement, shifts, rotates and load,
  with the next condition codes for each
*/
`timescale 1ns/1ps

module alu (
  input  cpu_isa_pkg::alu_op_t op,
  input  cpu_bus_pkg::data_t   operand,
  input  cpu_isa_pkg::cc_t     cc_in,
  output cpu_bus_pkg::data_t   result,
  output cpu_isa_pkg::cc_t     cc_out
);
  import cpu_isa_pkg::*;

  always_comb begin
    // E, F, H, I always carried through
    result = operand;
    cc_out = cc_in;

    case (op)
      ALU_CLR: begin
        result         = 8'h00;
        cc_out.flags.v = 1'b0;
        cc_out.flags.c = 1'b0;
      end
      // Carry left alone, overflow only on 7F
      ALU_INC: begin
        result         = operand + 8'd1;
        cc_out.flags.v = (operand == 8'h7F);
      end
      ALU_COM: begin
        result         = ~operand;
        cc_out.flags.v = 1'b0;
        cc_out.flags.c = 1'b1;
      end
      // Left shifts: V is the sign change
      ALU_ASL: begin
        result         = {operand[6:0], 1'b0};
        cc_out.flags.v = operand[7] ^ operand[6];
        cc_out.flags.c = operand[7];
      end
      ALU_ROL: begin
        result         = {operand[6:0], cc_in.flags.c};
        cc_out.flags.v = operand[7] ^ operand[6];
        cc_out.flags.c = operand[7];
      end
      // Right shifts keep V, bit 0 goes to carry
      ALU_ASR: begin
        result         = {operand[7], operand[7:1]};
        cc_out.flags.c = operand[0];
      end
      // N ends up 0 since bit 7 is cleared
      ALU_LSR: begin
        result         = {1'b0, operand[7:1]};
        cc_out.flags.c = operand[0];
      end
      ALU_ROR: begin
        result         = {cc_in.flags.c, operand[7:1]};
        cc_out.flags.c = operand[0];
      end
      ALU_LD: begin
        cc_out.flags.v = 1'b0;
      end
      default: ;
    endcase

    // N and Z track the result for every real operation
    if (op != ALU_NONE) begin
      cc_out.flags.n = result[7];
      cc_out.flags.z = (result == 8'h00);
    end
  end

endmodule

// ==== src/cpu_bus_pkg.sv ====
/*
  Bus-side definitions for the CPU slice
  Address and data words, reset vector location,
  one bus cycle request as a packed struct
*/
package cpu_bus_pkg;

  // 64K byte address space, big-endian words
  typedef logic [15:0] addr_t;

  // One memory byte
  typedef logic [7:0] data_t;

  // High byte of the reset vector, low byte at the next address
  localparam addr_t RESET_VECTOR = 16'hFFFE;

  // --------------------------------------------------
  // Bus request for the current cycle
  // --------------------------------------------------
  // write low means a read at addr
  // wdata only meaningful with write set
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
  } bus_cycle_t;

endpackage

// ==== src/cpu_isa_pkg.sv ====
/*
  Instruction-side definitions for the CPU slice
  Opcode fields, condition-code union and reset value,
  ALU operations, instruction lengths, TFR register codes,
  opcode constants and the decoded-instruction struct
*/
package cpu_isa_pkg;

  // Instruction register split into row and column nibbles
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } opcode_t;

  // CC flags, MSB first as in the CC byte
  typedef struct packed {
    logic e;
    logic f;
    logic h;
    logic i;
    logic n;
    logic z;
    logic v;
    logic c;
  } cc_flags_t;

  // Same byte seen raw (reset, TFR) or as named flags (ALU)
  typedef union packed {
    cpu_bus_pkg::data_t raw;
    cc_flags_t          flags;
  } cc_t;

  // E, F and I set out of reset
  localparam cpu_bus_pkg::data_t CC_RESET = 8'hD0;

  typedef enum logic [3:0] {
    ALU_NONE,
    ALU_CLR,
    ALU_INC,
    ALU_COM,
    ALU_ASL,
    ALU_ASR,
    ALU_LSR,
    ALU_ROL,
    ALU_ROR,
    ALU_LD
  } alu_op_t;

  // Bytes to fetch; a 3-byte store also takes a write cycle
  typedef enum logic [1:0] {
    LEN_1,
    LEN_2,
    LEN_3_STORE
  } inst_len_t;

  // TFR post-byte nibble codes, anything else is ignored
  typedef enum logic [3:0] {
    REG_A  = 4'h8,
    REG_B  = 4'h9,
    REG_CC = 4'hA
  } reg_sel_t;

  // --------------------------------------------------
  // Opcode rows and full opcodes
  // --------------------------------------------------
  localparam logic [3:0] ROW_INH_A = 4'h4;
  localparam logic [3:0] ROW_INH_B = 4'h5;
  localparam logic [3:0] ROW_IMM_A = 4'h8;
  localparam logic [3:0] ROW_IMM_B = 4'hC;

  localparam logic [7:0] OP_TFR     = 8'h1F;
  localparam logic [7:0] OP_STA_EXT = 8'hB7;
  localparam logic [7:0] OP_STB_EXT = 8'hF7;

  // Columns of the inherent ALU group
  localparam logic [3:0] COL_COM = 4'h3;
  localparam logic [3:0] COL_LSR = 4'h4;
  localparam logic [3:0] COL_ROR = 4'h6;
  localparam logic [3:0] COL_ASR = 4'h7;
  localparam logic [3:0] COL_ASL = 4'h8;
  localparam logic [3:0] COL_ROL = 4'h9;
  localparam logic [3:0] COL_INC = 4'hC;
  localparam logic [3:0] COL_CLR = 4'hF;
  // Immediate load shares column 6 with ROR
  localparam logic [3:0] COL_LD  = 4'h6;

  // Everything execute needs from one opcode
  typedef struct packed {
    inst_len_t len;
    alu_op_t   op;
    logic      dest_b;
    logic      tfr;
    logic      store;
    logic      store_b;
  } decoded_t;

endpackage

// ==== src/cpu_top.sv ====
/*
  CPU slice top level
  Fetch sequencer, decoder, register file and LSU,
  with the bus request unpacked onto the pins
*/
`timescale 1ns/1ps

module cpu_top (
  input  logic               clk,
  input  logic               reset_b,
  output cpu_bus_pkg::addr_t addr,
  output logic               data_rw_n,
  output cpu_bus_pkg::data_t data_out,
  input  cpu_bus_pkg::data_t data_in
);
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  addr_t      pc;
  opcode_t    ir;
  data_t      pb;
  data_t      b2;
  data_t      store_data;
  logic       exec;
  logic       vec_busy;
  decoded_t   dec;
  bus_cycle_t bus;

  fetch_sequencer fetch_sequencer_inst (
    .clk      (clk),
    .reset_b  (reset_b),
    .data_in  (data_in),
    .vec_busy (vec_busy),
    .dec      (dec),
    .pc       (pc),
    .ir       (ir),
    .pb       (pb),
    .b2       (b2),
    .exec     (exec)
  );

  opcode_decoder opcode_decoder_inst (
    .ir  (ir),
    .dec (dec)
  );

  register_file register_file_inst (
    .clk        (clk),
    .reset_b    (reset_b),
    .exec       (exec),
    .dec        (dec),
    .pb         (pb),
    .store_data (store_data)
  );

  // Store target is the two address bytes, high first
  load_store_unit load_store_unit_inst (
    .clk        (clk),
    .reset_b    (reset_b),
    .exec       (exec),
    .store      (dec.store),
    .pc         (pc),
    .target     ({pb, b2}),
    .store_data (store_data),
    .vec_busy   (vec_busy),
    .bus        (bus)
  );

  // Pins, read is the high level
  assign addr      = bus.addr;
  assign data_rw_n = ~bus.write;
  assign data_out  = bus.wdata;

endmodule

// ==== src/fetch_sequencer.sv ====
/*
  Fetch sequencer
  One-hot fetch FSM, instruction and operand byte capture,
  program counter with reset vector load, execute pulse
*/
`timescale 1ns/1ps

module fetch_sequencer (
  input  logic                  clk,
  input  logic                  reset_b,
  input  cpu_bus_pkg::data_t    data_in,
  input  logic                  vec_busy,
  input  cpu_isa_pkg::decoded_t dec,
  output cpu_bus_pkg::addr_t    pc,
  output cpu_isa_pkg::opcode_t  ir,
  output cpu_bus_pkg::data_t    pb,
  output cpu_bus_pkg::data_t    b2,
  output logic                  exec
);
  import cpu_isa_pkg::*;

  // State names say what is held, not what is on the bus
  typedef enum logic [4:0] {
    ST_WAIT   = 5'b0_0001, // Vector load, or nothing held yet
    ST_IR     = 5'b0_0010, // Opcode held
    ST_PB_IMM = 5'b0_0100, // Post-byte or immediate held
    ST_B2     = 5'b0_1000, // Address high byte held
    ST_B3     = 5'b1_0000  // Address low byte held, write cycle
  } fetch_state_t;

  fetch_state_t state;
  fetch_state_t state_next;
  logic         vec_cycle;
  logic         opcode_cycle;
  logic         pb_cycle;
  logic         b2_cycle;
  logic         pc_advance;

  assign vec_cycle = (state == ST_WAIT) && vec_busy;

  // --------------------------------------------------
  // Next state and byte capture strobes
  // --------------------------------------------------
  always_comb begin
    state_next   = state;
    opcode_cycle = 1'b0;
    pb_cycle     = 1'b0;
    b2_cycle     = 1'b0;
    exec         = 1'b0;
    pc_advance   = 1'b1;
    case (state)
      ST_WAIT: begin
        pc_advance = !vec_busy;
        if (!vec_busy) begin
          opcode_cycle = 1'b1;
          state_next   = ST_IR;
        end
      end
      ST_IR: begin
        case (dec.len)
          // Execute now, next opcode already on the bus
          LEN_1: begin
            exec         = 1'b1;
            opcode_cycle = 1'b1;
          end
          LEN_2: begin
            pb_cycle   = 1'b1;
            state_next = ST_PB_IMM;
          end
          default: begin
            pb_cycle   = 1'b1;
            state_next = ST_B2;
          end
        endcase
      end
      ST_PB_IMM: begin
        exec         = 1'b1;
        opcode_cycle = 1'b1;
        state_next   = ST_IR;
      end
      ST_B2: begin
        b2_cycle   = 1'b1;
        state_next = ST_B3;
      end
      // Bus is busy with the write, PC holds
      ST_B3: begin
        exec       = 1'b1;
        pc_advance = 1'b0;
        state_next = ST_WAIT;
      end
      default: begin
        pc_advance = 1'b0;
        state_next = ST_WAIT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= ST_WAIT;
      pc    <= 16'h0000;
    end else begin
      state <= state_next;
      // Vector bytes shift in big-endian, high byte first
      if (vec_cycle) begin
        pc <= {pc[7:0], data_in};
      end else if (pc_advance) begin
        pc <= pc + 16'd1;
      end
    end
  end

  // Opcode and operand byte capture
  always_ff @(posedge clk) begin
    if (opcode_cycle) begin
      ir <= opcode_t'(data_in);
    end
    if (pb_cycle) begin
      pb <= data_in;
    end
    if (b2_cycle) begin
      b2 <= data_in;
    end
  end

endmodule

// ==== src/load_store_unit.sv ====
/*
  Load/store unit
  Reset vector fetch cycles, store write cycles,
  and the bus request mux between PC and LSU
*/
`timescale 1ns/1ps

module load_store_unit (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    exec,
  input  logic                    store,
  input  cpu_bus_pkg::addr_t      pc,
  input  cpu_bus_pkg::addr_t      target,
  input  cpu_bus_pkg::data_t      store_data,
  output logic                    vec_busy,
  output cpu_bus_pkg::bus_cycle_t bus
);
  import cpu_bus_pkg::*;

  typedef enum logic [1:0] {
    LSU_VEC_MSB,
    LSU_VEC_LSB,
    LSU_IDLE
  } lsu_state_t;

  lsu_state_t state;

  // Vector load runs once out of reset, then parks in idle
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= LSU_VEC_MSB;
    end else begin
      case (state)
        LSU_VEC_MSB: state <= LSU_VEC_LSB;
        default:     state <= LSU_IDLE;
      endcase
    end
  end

  assign vec_busy = (state != LSU_IDLE);

  // --------------------------------------------------
  // Bus request for this cycle
  // --------------------------------------------------
  always_comb begin
    bus.addr  = pc;
    bus.write = 1'b0;
    bus.wdata = 8'h00;
    case (state)
      LSU_VEC_MSB: bus.addr = RESET_VECTOR;
      LSU_VEC_LSB: bus.addr = RESET_VECTOR + 16'd1;
      default: begin
        // Store execute cycle takes the bus from fetch
        if (exec && store) begin
          bus.addr  = target;
          bus.write = 1'b1;
          bus.wdata = store_data;
        end
      end
    endcase
  end

endmodule

// ==== src/opcode_decoder.sv ====
/*
  Opcode decoder
  Row/column decode of the instruction register into
  length, ALU operation, destination, TFR and store controls
*/
`timescale 1ns/1ps

module opcode_decoder (
  input  cpu_isa_pkg::opcode_t  ir,
  output cpu_isa_pkg::decoded_t dec
);
  import cpu_isa_pkg::*;

  always_comb begin
    // Unknown opcodes fall out as one-byte no-ops
    dec = '{len: LEN_1, op: ALU_NONE, dest_b: 1'b0, tfr: 1'b0, store: 1'b0, store_b: 1'b0};

    case (ir.row)
      // Inherent ALU group on A or B
      ROW_INH_A, ROW_INH_B: begin
        dec.dest_b = (ir.row == ROW_INH_B);
        case (ir.col)
          COL_COM: dec.op = ALU_COM;
          COL_LSR: dec.op = ALU_LSR;
          COL_ROR: dec.op = ALU_ROR;
          COL_ASR: dec.op = ALU_ASR;
          COL_ASL: dec.op = ALU_ASL;
          COL_ROL: dec.op = ALU_ROL;
          COL_INC: dec.op = ALU_INC;
          COL_CLR: dec.op = ALU_CLR;
          default: dec.op = ALU_NONE;
        endcase
      end
      // Immediates always take the operand byte
      ROW_IMM_A, ROW_IMM_B: begin
        dec.len    = LEN_2;
        dec.dest_b = (ir.row == ROW_IMM_B);
        // Only LD does anything here
        if (ir.col == COL_LD) begin
          dec.op = ALU_LD;
        end
      end
      default: ;
    endcase

    // Post-byte holds source and destination codes
    if (ir == OP_TFR) begin
      dec.len = LEN_2;
      dec.tfr = 1'b1;
    end

    // Extended stores carry a two-byte address
    if (ir == OP_STA_EXT || ir == OP_STB_EXT) begin
      dec.len     = LEN_3_STORE;
      dec.store   = 1'b1;
      dec.store_b = (ir == OP_STB_EXT);
    end
  end

endmodule

// ==== src/register_file.sv ====
/*
  Register file
  A and B accumulators and the CC register,
  ALU write-back, TFR moves and store data select
*/
`timescale 1ns/1ps

module register_file (
  input  logic                  clk,
  input  logic                  reset_b,
  input  logic                  exec,
  input  cpu_isa_pkg::decoded_t dec,
  input  cpu_bus_pkg::data_t    pb,
  output cpu_bus_pkg::data_t    store_data
);
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  data_t    a;
  data_t    b;
  cc_t      cc;
  data_t    alu_operand;
  data_t    alu_result;
  cc_t      alu_cc;
  reg_sel_t tfr_src;
  reg_sel_t tfr_dst;
  data_t    tfr_value;
  logic     tfr_src_ok;

  // LD takes the immediate, everything else its own accumulator
  assign alu_operand = (dec.op == ALU_LD) ? pb : (dec.dest_b ? b : a);

  alu alu_inst (
    .op      (dec.op),
    .operand (alu_operand),
    .cc_in   (cc),
    .result  (alu_result),
    .cc_out  (alu_cc)
  );

  // --------------------------------------------------
  // TFR source select, post-byte high nibble
  // --------------------------------------------------
  assign tfr_src = reg_sel_t'(pb[7:4]);
  assign tfr_dst = reg_sel_t'(pb[3:0]);

  always_comb begin
    tfr_src_ok = 1'b1;
    case (tfr_src)
      REG_A:   tfr_value = a;
      REG_B:   tfr_value = b;
      REG_CC:  tfr_value = cc.raw;
      default: begin
        tfr_value  = a;
        tfr_src_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a      <= 8'h00;
      b      <= 8'h00;
      cc.raw <= CC_RESET;
    end else if (exec) begin
      if (dec.tfr) begin
        // Unknown destination falls through the default
        if (tfr_src_ok) begin
          case (tfr_dst)
            REG_A:   a      <= tfr_value;
            REG_B:   b      <= tfr_value;
            REG_CC:  cc.raw <= tfr_value;
            default: ;
          endcase
        end
      end else if (dec.op != ALU_NONE) begin
        if (dec.dest_b) begin
          b <= alu_result;
        end else begin
          a <= alu_result;
        end
        cc <= alu_cc;
      end
    end
  end

  // STB writes B, STA writes A
  assign store_data = dec.store_b ? b : a;

endmodule

// ==== verification/cpu_tb.sv ====
/*
  Testbench for the CPU slice
  Clock, reset, 64K memory bus model, random program generator,
  reference model of A, B and CC, expected bus-cycle checks
*/
`timescale 1ns/1ps

module cpu_tb;
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;

  localparam int    NUM_INST     = 200;
  localparam int    NUM_DIRECTED = 14;
  localparam int    CYCLE_LIMIT  = 4 * NUM_INST + 20;
  localparam addr_t PROG_START   = 16'h1000;

  logic       clk;
  logic       reset_b;
  addr_t      addr;
  logic       data_rw_n;
  data_t      data_out;
  data_t      data_in;

  data_t      mem [0:65535];
  bus_cycle_t exp_q [$];
  bus_cycle_t head;
  integer     seed = 32'he78e1e02;
  int         cycles = 0;
  int         writes_expected = 0;
  int         writes_seen = 0;
  addr_t      gen_pc;
  addr_t      fill_addr;
  addr_t      target;
  logic [31:0] r;
  logic [3:0] col;
  logic       dest_b;
  data_t      post;

  // Reference model registers
  data_t      m_a;
  data_t      m_b;
  cc_t        m_cc;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .reset_b   (reset_b),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out),
    .data_in   (data_in)
  );

  // Memory answers within the cycle
  assign data_in = mem[addr];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit of four cycles per instruction at worst
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: program did not finish");
      $display("STATUS: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // Every write cycle on the bus, reset included
  always @(negedge clk) begin
    if (data_rw_n !== 1'b1) begin
      writes_seen <= writes_seen + 1;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic stop_on_mismatch();
    $display("STATUS: FAIL");
    $fatal(1, "bus mismatch");
  endtask

  task automatic check_addr(input addr_t got, input addr_t expv);
    if (got !== expv) begin
      $display("FAILED at time %0t: address %h, expected %h", $time, got, expv);
      stop_on_mismatch();
    end
  endtask

  task automatic check_rw(input logic got, input logic expv);
    if (got !== expv) begin
      $display("FAILED at time %0t: data_rw_n %b, expected %b", $time, got, expv);
      stop_on_mismatch();
    end
  endtask

  task automatic check_data(input data_t got, input data_t expv);
    if (got !== expv) begin
      $display("FAILED at time %0t: write data %h, expected %h", $time, got, expv);
      stop_on_mismatch();
    end
  endtask

  // --------------------------------------------------
  // Reference model of the flag table
  // --------------------------------------------------
  task automatic model_alu(input alu_op_t op, input logic to_b, input data_t x);
    data_t res;
    logic  v;
    logic  c;
    v = m_cc.flags.v;
    c = m_cc.flags.c;
    // Result column
    case (op)
      ALU_CLR: res = 8'h00;
      ALU_INC: res = x + 8'd1;
      ALU_COM: res = ~x;
      ALU_ASL: res = {x[6:0], 1'b0};
      ALU_ROL: res = {x[6:0], m_cc.flags.c};
      ALU_ASR: res = {x[7], x[7:1]};
      ALU_LSR: res = {1'b0, x[7:1]};
      ALU_ROR: res = {m_cc.flags.c, x[7:1]};
      // Immediate load
      default: res = x;
    endcase
    // Overflow column
    case (op)
      ALU_INC:                   v = (x == 8'h7F);
      ALU_ASL, ALU_ROL:          v = x[7] ^ x[6];
      ALU_ASR, ALU_LSR, ALU_ROR: ;
      default:                   v = 1'b0;
    endcase
    // Carry column, INC and LD keep it
    case (op)
      ALU_CLR:                   c = 1'b0;
      ALU_COM:                   c = 1'b1;
      ALU_ASL, ALU_ROL:          c = x[7];
      ALU_ASR, ALU_LSR, ALU_ROR: c = x[0];
      default: ;
    endcase
    m_cc.flags.n = res[7];
    m_cc.flags.z = (res == 8'h00);
    m_cc.flags.v = v;
    m_cc.flags.c = c;
    if (to_b) m_b = res;
    else m_a = res;
  endtask

  // Unknown source or destination code leaves everything alone
  task automatic model_tfr(input data_t pbyte);
    data_t v;
    logic  ok;
    ok = 1'b1;
    v  = 8'h00;
    case (pbyte[7:4])
      4'h8: v = m_a;
      4'h9: v = m_b;
      4'hA: v = m_cc.raw;
      default: ok = 1'b0;
    endcase
    if (ok) begin
      case (pbyte[3:0])
        4'h8: m_a = v;
        4'h9: m_b = v;
        4'hA: m_cc.raw = v;
        default: ;
      endcase
    end
  endtask

  // --------------------------------------------------
  // Program emission
  // --------------------------------------------------
  task automatic push_event(input addr_t a, input logic w, input data_t d);
    bus_cycle_t ev;
    ev.addr  = a;
    ev.write = w;
    ev.wdata = d;
    exp_q.push_back(ev);
  endtask

  // Every program byte is fetched once and in order
  task automatic put_byte(input data_t v);
    mem[gen_pc] = v;
    push_event(gen_pc, 1'b0, 8'h00);
    gen_pc = gen_pc + 16'd1;
  endtask

  task automatic emit_inh(input logic to_b, input logic [2:0] k);
    logic [3:0] c;
    alu_op_t    op;
    case (k)
      3'd0: begin c = 4'h3; op = ALU_COM; end
      3'd1: begin c = 4'h4; op = ALU_LSR; end
      3'd2: begin c = 4'h6; op = ALU_ROR; end
      3'd3: begin c = 4'h7; op = ALU_ASR; end
      3'd4: begin c = 4'h8; op = ALU_ASL; end
      3'd5: begin c = 4'h9; op = ALU_ROL; end
      3'd6: begin c = 4'hC; op = ALU_INC; end
      default: begin c = 4'hF; op = ALU_CLR; end
    endcase
    put_byte({to_b ? 4'h5 : 4'h4, c});
    model_alu(op, to_b, to_b ? m_b : m_a);
  endtask

  task automatic emit_ld(input logic to_b, input data_t imm);
    put_byte(to_b ? 8'hC6 : 8'h86);
    put_byte(imm);
    model_alu(ALU_LD, to_b, imm);
  endtask

  task automatic emit_tfr(input data_t pbyte);
    put_byte(8'h1F);
    put_byte(pbyte);
    model_tfr(pbyte);
  endtask

  // Address bytes and then one write cycle of the accumulator
  task automatic emit_store(input logic from_b, input addr_t where);
    put_byte(from_b ? 8'hF7 : 8'hB7);
    put_byte(where[15:8]);
    put_byte(where[7:0]);
    push_event(where, 1'b1, from_b ? m_b : m_a);
    writes_expected++;
  endtask

  // Mostly A, B or CC and now and then any nibble
  function automatic logic [3:0] pick_reg(input data_t rb);
    if (rb[7:6] == 2'b00) return rb[3:0];
    case (rb[1:0])
      2'd0: return 4'h8;
      2'd1: return 4'h9;
      default: return 4'hA;
    endcase
  endfunction

  // Unused columns of rows 4 and 5
  function automatic data_t pick_nop(input logic [2:0] k, input logic row_b);
    logic [3:0] c;
    case (k)
      3'd0: c = 4'h0;
      3'd1: c = 4'h1;
      3'd2: c = 4'h2;
      3'd3: c = 4'h5;
      3'd4: c = 4'hA;
      3'd5: c = 4'hB;
      3'd6: c = 4'hD;
      default: c = 4'hE;
    endcase
    return {row_b ? 4'h5 : 4'h4, c};
  endfunction

  // --------------------------------------------------
  // Stimulus and bus monitor
  // --------------------------------------------------
  initial begin
    reset_b = 1'b0;
    m_a = 8'h00;
    m_b = 8'h00;
    m_cc.raw = 8'hD0;

    // Background fill from the full address
    for (int i = 0; i < 65536; i++) begin
      fill_addr = addr_t'(i);
      mem[fill_addr] = fill_addr[15:8] ^ fill_addr[7:0];
    end

    // Big-endian vector load
    mem[16'hFFFE] = PROG_START[15:8];
    mem[16'hFFFF] = PROG_START[7:0];
    push_event(16'hFFFE, 1'b0, 8'h00);
    push_event(16'hFFFF, 1'b0, 8'h00);
    gen_pc = PROG_START;

    // Directed start with CC out of reset and TFR into CC
    emit_tfr(8'hA8);
    emit_store(1'b0, 16'h8000);
    emit_ld(1'b0, 8'hD1);
    emit_tfr(8'h8A);
    emit_ld(1'b0, 8'h00);
    emit_inh(1'b0, 3'd5);
    emit_store(1'b0, 16'h8001);
    // Unknown source into B, then A into an unknown destination
    emit_tfr(8'h39);
    emit_tfr(8'h8B);
    emit_store(1'b1, 16'h8002);
    // Immediate loads straight into stores
    emit_ld(1'b1, 8'h5A);
    emit_store(1'b1, 16'h8003);
    emit_ld(1'b0, 8'hA5);
    emit_store(1'b0, 16'h8004);

    for (int n = NUM_DIRECTED; n < NUM_INST; n++) begin
      r = $random(seed);
      if (r[3:0] < 4'd6) begin
        emit_inh(r[7], r[6:4]);
      end else if (r[3:0] < 4'd8) begin
        emit_ld(r[7], r[15:8]);
      end else if (r[3:0] == 4'd8) begin
        // Two-byte immediate that does nothing
        col = r[7:4];
        if (col == 4'h6) col = 4'h7;
        put_byte({r[8] ? 4'hC : 4'h8, col});
        put_byte(r[23:16]);
      end else if (r[3:0] == 4'd9) begin
        put_byte(pick_nop(r[10:8], r[11]));
      end else if (r[3:0] < 4'd12) begin
        post = {pick_reg(r[15:8]), pick_reg(r[23:16])};
        emit_tfr(post);
      end else begin
        dest_b = r[7];
        target = {8'h80 + (r[15:8] % 8'h7F), r[23:16]};
        emit_store(dest_b, target);
      end
    end
    // Fetch of the byte after the program ends the run
    push_event(gen_pc, 1'b0, 8'h00);

    repeat (5) @(posedge clk);
    reset_b <= 1'b1;

    // Sample each bus cycle mid-period
    while (exp_q.size() > 0) begin
      @(negedge clk);
      head = exp_q.pop_front();
      check_addr(addr, head.addr);
      check_rw(data_rw_n, ~head.write);
      if (head.write) begin
        check_data(data_out, head.wdata);
      end
    end

    if (writes_seen == writes_expected) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("DUT write cycle count does not match the program");
      $display("STATUS: FAIL");
      $fatal(1, "write count mismatch");
    end
  end

endmodule
